// File: Makefile
# Verilator build and run of the XGMII receive MAC testbench

VERILATOR ?= verilator
TOP       ?= xgmii_rx_mac_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+test
verilog/xgmii_rx_pkg.sv
verilog/xgmii_rx_decode.sv
verilog/rx_crc32.sv
verilog/rx_frame_check.sv
verilog/xgmii_rx_mac.sv
test/xgmii_rx_mac_tb.sv

// File: test/xgmii_rx_frames.svh
// Fault kinds applied to a frame
localparam int FAULT_NONE     = 0;
localparam int FAULT_FCS      = 1;  // one FCS bit flipped
localparam int FAULT_CTL_ERR  = 2;
localparam int FAULT_PREAMBLE = 3;
localparam int FAULT_STALL    = 4;  // payload of the entry before, sent with valid gaps

// Columns: test name, payload length in bytes, fault kind, expected rx_error
task automatic load_frame_table();
	add_frame("aligned_16",      16, FAULT_NONE,     1'b0);
	add_frame("aligned_64",      64, FAULT_NONE,     1'b0);
	add_frame("single_word_4",    4, FAULT_NONE,     1'b0);
	add_frame("rem1_17",         17, FAULT_NONE,     1'b0);
	add_frame("rem2_18",         18, FAULT_NONE,     1'b0);
	add_frame("rem3_19",         19, FAULT_NONE,     1'b0);
	add_frame("rem2_46",         46, FAULT_NONE,     1'b0);
	add_frame("tiny_1",           1, FAULT_NONE,     1'b0);
	add_frame("tiny_2",           2, FAULT_NONE,     1'b0);
	add_frame("tiny_3",           3, FAULT_NONE,     1'b0);
	add_frame("fcs_flip_33",     33, FAULT_FCS,      1'b1);
	add_frame("body_error_40",   40, FAULT_CTL_ERR,  1'b1);
	add_frame("bad_preamble_24", 24, FAULT_PREAMBLE, 1'b0);
	add_frame("after_drop_21",   21, FAULT_NONE,     1'b0);
	add_frame("stalled_21",      21, FAULT_STALL,    1'b0);
	add_frame("long_60",         60, FAULT_NONE,     1'b0);
	add_frame("stalled_60",      60, FAULT_STALL,    1'b0);
endtask

// File: test/xgmii_rx_mac_tb.sv
`timescale 1ns/1ns

module xgmii_rx_mac_tb;
	import xgmii_rx_pkg::*;

	localparam int CLK_PERIOD     = 40;
	localparam int SEED           = 85;
	localparam int RESET_CYCLES   = 10;
	localparam int IDLE_GAP       = 6;
	localparam int TIMEOUT_FACTOR = 4;
	// Payload word that carries the error character in an aborted frame
	localparam int ERR_WORD       = 2;

	localparam xgmii_data_t IDLE_WORD = {4{XGMII_CTL_IDLE}};

	logic        xgmii_rx_clk;
	logic        reset;
	logic        xgmii_rx_valid;
	xgmii_ctl_t  xgmii_rx_ctl;
	xgmii_data_t xgmii_rx_data;
	logic        rx_valid;
	xgmii_data_t rx_data;
	byte_count_t rx_keep;
	logic        rx_last;
	logic        rx_error;

	// Frame table columns
	string frame_name[$];
	int    frame_len[$];
	int    frame_fault[$];
	logic  frame_err[$];
	logic  table_loaded = 1'b0;

	// Beats seen at the DUT output for the current frame
	xgmii_data_t got_data[$];
	byte_count_t got_keep[$];
	logic        got_err[$];

	int seed;
	int data_errors;
	int keep_errors;
	int flag_errors;
	int other_errors;

	`include "xgmii_rx_frames.svh"

	xgmii_rx_mac xgmii_rx_mac_inst (
		.xgmii_rx_clk   (xgmii_rx_clk),
		.reset          (reset),
		.xgmii_rx_valid (xgmii_rx_valid),
		.xgmii_rx_ctl   (xgmii_rx_ctl),
		.xgmii_rx_data  (xgmii_rx_data),
		.rx_valid       (rx_valid),
		.rx_data        (rx_data),
		.rx_keep        (rx_keep),
		.rx_last        (rx_last),
		.rx_error       (rx_error)
	);

	initial begin
		xgmii_rx_clk = 1'b0;
		forever #(CLK_PERIOD/2) xgmii_rx_clk = ~xgmii_rx_clk;
	end

	task automatic add_frame(input string name, input int len, input int fault,
		input logic err);
		frame_name.push_back(name);
		frame_len.push_back(len);
		frame_fault.push_back(fault);
		frame_err.push_back(err);
	endtask

	//////////////////////////////
	// Reference model

	// Ethernet CRC-32 as a serial LFSR with bits going in LSB first
	function automatic crc_t ref_fcs(input xgmii_char_t data_bytes[$]);
		crc_t        c;
		xgmii_char_t d;
		logic        fb;
		c = CRC_INIT;
		foreach (data_bytes[i]) begin
			d = data_bytes[i];
			repeat (8) begin
				fb = c[0] ^ d[0];
				c = c >> 1;
				d = d >> 1;
				if (fb) begin
					c = c ^ CRC_POLY;
				end
			end
		end
		return ~c;
	endfunction

	//////////////////////////////
	// XGMII driver

	// Optional random stall cycles ahead of the word with junk data while valid is low
	task automatic send_word(input xgmii_data_t d, input xgmii_ctl_t c, input logic stall);
		int gaps;
		gaps = stall ? int'($unsigned($random(seed)) % 3) : 0;
		repeat (gaps) begin
			@(posedge xgmii_rx_clk);
			xgmii_rx_valid <= 1'b0;
			xgmii_rx_ctl <= 4'h0;
			xgmii_rx_data <= $random(seed);
		end
		@(posedge xgmii_rx_clk);
		xgmii_rx_valid <= 1'b1;
		xgmii_rx_ctl <= c;
		xgmii_rx_data <= d;
	endtask

	// Start, preamble/SFD, then payload and FCS with the end character packed behind
	task automatic send_frame(input xgmii_char_t frame_bytes[$], input int fault);
		logic        stall;
		int          nwords;
		int          k;
		xgmii_data_t d;
		xgmii_ctl_t  c;
		stall = (fault == FAULT_STALL);
		send_word({XGMII_CTL_START, 24'h555555}, 4'b1000, stall);
		if (fault == FAULT_PREAMBLE) begin
			send_word(PREAMBLE_SFD_WORD ^ 32'h1, 4'h0, stall);
		end else begin
			send_word(PREAMBLE_SFD_WORD, 4'h0, stall);
		end
		nwords = (frame_bytes.size() + 4) / 4;
		for (int w = 0; w < nwords; w++) begin
			// Lane 3 is filled first so bytes shift in from the bottom
			for (int l = 0; l < 4; l++) begin
				k = 4*w + l;
				if (k < frame_bytes.size()) begin
					d = {d[23:0], frame_bytes[k]};
					c = {c[2:0], 1'b0};
				end else if (k == frame_bytes.size()) begin
					d = {d[23:0], XGMII_CTL_END};
					c = {c[2:0], 1'b1};
				end else begin
					d = {d[23:0], XGMII_CTL_IDLE};
					c = {c[2:0], 1'b1};
				end
			end
			if ((fault == FAULT_CTL_ERR) && (w == ERR_WORD)) begin
				d[31:24] = XGMII_CTL_ERROR;
				c[3] = 1'b1;
			end
			send_word(d, c, stall);
		end
	endtask

	//////////////////////////////
	// Output monitor and checks

	always @(negedge xgmii_rx_clk) begin
		if (!reset) begin
			if (rx_valid) begin
				got_data.push_back(rx_data);
				got_keep.push_back(rx_keep);
			end
			if (rx_last) begin
				got_err.push_back(rx_error);
			end
			if (rx_valid && rx_last) begin
				$display("status beat at %0t lands on a data beat", $time);
				other_errors++;
			end
		end
	end

	task automatic compare_data(input string name, input int idx, input xgmii_data_t expected,
		input xgmii_data_t actual);
		if (actual !== expected) begin
			$display("error %s word %0d data expected %h actual %h", name, idx, expected, actual);
			data_errors++;
		end
	endtask

	task automatic compare_keep(input string name, input int idx, input byte_count_t expected,
		input byte_count_t actual);
		if (actual !== expected) begin
			$display("error %s word %0d keep expected %0d actual %0d", name, idx, expected, actual);
			keep_errors++;
		end
	endtask

	task automatic compare_error(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s rx_error expected %b actual %b", name, expected, actual);
			flag_errors++;
		end
	endtask

	task automatic check_frame(input string name, input xgmii_char_t payload[$], input int fault,
		input logic exp_err);
		int          n_words;
		int          n_lasts;
		int          k;
		xgmii_data_t exp_d;
		xgmii_data_t mask;
		// Dropped frame gives nothing and an aborted one stops a word short of the error
		if (fault == FAULT_PREAMBLE) begin
			n_words = 0;
		end else if (fault == FAULT_CTL_ERR) begin
			n_words = ERR_WORD - 1;
		end else begin
			n_words = (payload.size() + 3) / 4;
		end
		n_lasts = (fault == FAULT_PREAMBLE) ? 0 : 1;
		if (got_data.size() != n_words) begin
			$display("%s gave %0d data beats instead of %0d", name, got_data.size(), n_words);
			other_errors++;
		end
		for (int w = 0; (w < n_words) && (w < got_data.size()); w++) begin
			k = 4;
			if ((fault != FAULT_CTL_ERR) && (w == n_words - 1) && (payload.size() % 4 != 0)) begin
				k = payload.size() % 4;
			end
			// First wire byte in the low byte and bytes past keep ignored
			for (int i = 0; i < 4; i++) begin
				exp_d = {(i < k) ? payload[4*w + i] : 8'h00, exp_d[31:8]};
				mask = {(i < k) ? 8'hff : 8'h00, mask[31:8]};
			end
			compare_data(name, w, exp_d, got_data[w] & mask);
			compare_keep(name, w, byte_count_t'(k), got_keep[w]);
		end
		if (got_err.size() != n_lasts) begin
			$display("%s gave %0d status beats instead of %0d", name, got_err.size(), n_lasts);
			other_errors++;
		end else if (n_lasts == 1) begin
			compare_error(name, exp_err, got_err[0]);
		end
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		xgmii_char_t payload[$];
		xgmii_char_t frame_bytes[$];
		crc_t        fcs;
		logic        stall;
		int          idles;
		int          lasts_expected;
		reset <= 1'b1;
		xgmii_rx_valid <= 1'b0;
		xgmii_rx_ctl <= 4'hf;
		xgmii_rx_data <= IDLE_WORD;
		seed = SEED;
		data_errors = 0;
		keep_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		load_frame_table();
		table_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge xgmii_rx_clk);
		reset <= 1'b0;
		repeat (IDLE_GAP) send_word(IDLE_WORD, 4'hf, 1'b0);

		for (int f = 0; f < frame_len.size(); f++) begin
			// Stalled entry repeats the frame before it
			if ((frame_fault[f] != FAULT_STALL) || (payload.size() != frame_len[f])) begin
				payload = {};
				repeat (frame_len[f]) payload.push_back(xgmii_char_t'($random(seed)));
			end
			fcs = ref_fcs(payload);
			if (frame_fault[f] == FAULT_FCS) begin
				fcs = fcs ^ (crc_t'(1) << ($unsigned($random(seed)) % 32));
			end
			frame_bytes = payload;
			// FCS low byte goes first
			repeat (4) begin
				frame_bytes.push_back(fcs[7:0]);
				fcs = fcs >> 8;
			end

			got_data = {};
			got_keep = {};
			got_err = {};
			stall = (frame_fault[f] == FAULT_STALL);
			send_frame(frame_bytes, frame_fault[f]);

			// Idles keep the check pipe moving until the status beat
			lasts_expected = (frame_fault[f] == FAULT_PREAMBLE) ? 0 : 1;
			idles = 0;
			while (got_err.size() < lasts_expected) begin
				send_word(IDLE_WORD, 4'hf, stall);
				idles++;
			end
			while (idles < IDLE_GAP) begin
				send_word(IDLE_WORD, 4'hf, stall);
				idles++;
			end
			@(posedge xgmii_rx_clk);
			check_frame(frame_name[f], payload, frame_fault[f], frame_err[f]);
		end

		$display("Totals: data errors %0d, keep errors %0d, flag errors %0d, other errors %0d",
			data_errors, keep_errors, flag_errors, other_errors);
		if ((data_errors + keep_errors + flag_errors + other_errors) == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog sized from the table with stalls at most tripling a word
	initial begin
		int words;
		wait (table_loaded);
		words = RESET_CYCLES + IDLE_GAP;
		foreach (frame_len[i]) begin
			words += 2 + (frame_len[i] + 8) / 4 + IDLE_GAP;
		end
		#(words * CLK_PERIOD * TIMEOUT_FACTOR);
		$display("timeout: run did not finish within %0d clock cycles", words * TIMEOUT_FACTOR);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/rx_crc32.sv
`timescale 1ns/1ns

module rx_crc32 (
	input  logic                       xgmii_rx_clk,
	input  logic                       reset,
	input  logic                       crc_reset,
	input  logic                       crc_ce,
	input  xgmii_rx_pkg::byte_count_t  crc_len,
	input  xgmii_rx_pkg::crc_t         crc_din,
	output xgmii_rx_pkg::crc_t         crc_out
);
	import xgmii_rx_pkg::*;

	// Stage 1 holds the data-only contribution of a word
	crc_t        part_q;
	byte_count_t len_q;
	logic        ce_q;

	// Stage 2 holds the running remainder
	crc_t        crc_state;

	// Reflected CRC over len bytes, byte 0 in the low bits goes first
	function automatic crc_t crc_bytes(crc_t seed, crc_t data, byte_count_t len);
		crc_t c;
		c = seed;
		for (int i = 0; i < 4; i++) begin
			if (i < int'(len)) begin
				c = c ^ {24'h0, data[8*i +: 8]};
				// One bit per unrolled step
				for (int b = 0; b < 8; b++) begin
					c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
				end
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// Stage 1

	// CRC is linear so the data term can be formed without the running state
	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			ce_q <= 1'b0;
		end else begin
			ce_q <= crc_ce && !crc_reset;
		end
	end

	always_ff @(posedge xgmii_rx_clk) begin
		if (crc_ce) begin
			part_q <= crc_bytes(crc_t'(0), crc_din, crc_len);
			len_q <= crc_len;
		end
	end

	//////////////////////////////
	// Stage 2

	// Advance the old remainder by len zero bytes and fold in the data term
	always_ff @(posedge xgmii_rx_clk) begin
		if (reset || crc_reset) begin
			crc_state <= CRC_INIT;
		end else if (ce_q) begin
			crc_state <= crc_bytes(crc_state, crc_t'(0), len_q) ^ part_q;
		end
	end

	// Final complement, bit order already matches the FCS
	assign crc_out = ~crc_state;

	// Each word carries at least one byte
	a_len_range: assert property (@(posedge xgmii_rx_clk) disable iff (reset)
		crc_ce |-> ((crc_len >= 3'd1) && (crc_len <= 3'd4)));

endmodule

// File: verilog/rx_frame_check.sv
`timescale 1ns/1ns

module rx_frame_check (
	input  logic                xgmii_rx_clk,
	input  logic                reset,
	input  logic                step,
	input  xgmii_rx_pkg::crc_t  fcs_expected,
	input  logic                frame_end,
	input  logic                frame_abort,
	input  xgmii_rx_pkg::crc_t  crc_out,
	output logic                rx_last,
	output logic                rx_error
);
	import xgmii_rx_pkg::*;

	// One bit per CRC stage, set when a frame end is in flight
	logic [CRC_PIPE_DEPTH-1:0] pending;

	// Expected FCS travelling alongside the pending bit
	crc_t fcs_pipe [CRC_PIPE_DEPTH];

	//////////////////////////////
	// Pending flags and status beat

	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			pending <= '0;
			rx_last <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_last <= 1'b0;
			rx_error <= 1'b0;

			// Pipe only moves on accepted words
			if (step) begin
				pending <= {pending[CRC_PIPE_DEPTH-2:0], frame_end};
				// CRC of the closing word has settled by now
				if (pending[CRC_PIPE_DEPTH-1]) begin
					rx_last <= 1'b1;
					rx_error <= (fcs_pipe[CRC_PIPE_DEPTH-1] != crc_out);
				end
			end

			// Abort wins over any check in flight
			if (frame_abort) begin
				rx_last <= 1'b1;
				rx_error <= 1'b1;
				pending <= '0;
			end
		end
	end

	// FCS delay line, only the entry next to a pending bit matters
	always_ff @(posedge xgmii_rx_clk) begin
		if (step) begin
			fcs_pipe[0] <= fcs_expected;
			for (int i = 1; i < CRC_PIPE_DEPTH; i++) begin
				fcs_pipe[i] <= fcs_pipe[i-1];
			end
		end
	end

	// Status beat never lands on the beat that closes the payload
	a_last_alone: assert property (@(posedge xgmii_rx_clk) disable iff (reset)
		rx_last |-> !frame_end);

endmodule

// File: verilog/xgmii_rx_decode.sv
`timescale 1ns/1ns

module xgmii_rx_decode (
	input  logic                       xgmii_rx_clk,
	input  logic                       reset,
	input  logic                       xgmii_rx_valid,
	input  xgmii_rx_pkg::xgmii_ctl_t   xgmii_rx_ctl,
	input  xgmii_rx_pkg::xgmii_data_t  xgmii_rx_data,
	output logic                       rx_valid,
	output xgmii_rx_pkg::xgmii_data_t  rx_data,
	output xgmii_rx_pkg::byte_count_t  rx_keep,
	output logic                       crc_reset,
	output logic                       crc_ce,
	output xgmii_rx_pkg::byte_count_t  crc_len,
	output xgmii_rx_pkg::crc_t         crc_din,
	output xgmii_rx_pkg::crc_t         fcs_expected,
	output logic                       frame_end,
	output logic                       frame_abort,
	output logic                       step
);
	import xgmii_rx_pkg::*;

	// Lane hit masks for the word on the bus
	xgmii_ctl_t  end_lane;
	xgmii_ctl_t  err_lane;
	xgmii_ctl_t  start_low;

	rx_state_t   state;

	// Last accepted word, held until we know whether it is payload or FCS
	xgmii_data_t prev_data;
	logic        prev_preamble;

	// Split of the closing words into payload and FCS
	byte_count_t tail_keep;
	crc_t        tail_fcs;

	// First wire byte ends up in the low byte
	function automatic xgmii_data_t swap_bytes(xgmii_data_t d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	//////////////////////////////
	// Control character decode

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			end_lane[i] = xgmii_rx_ctl[i] && (xgmii_rx_data[8*i +: 8] == XGMII_CTL_END);
			err_lane[i] = xgmii_rx_ctl[i] && (xgmii_rx_data[8*i +: 8] == XGMII_CTL_ERROR);
			start_low[i] = xgmii_rx_ctl[i] && (xgmii_rx_data[8*i +: 8] == XGMII_CTL_START);
		end
		// Lane 3 is the only legal place for a start
		start_low[3] = 1'b0;
	end

	//////////////////////////////
	// Tail split

	// Earliest end lane wins
	// Bytes of prev_data ahead of the end position minus four FCS bytes are payload
	always_comb begin
		if (end_lane[3]) begin
			// Whole previous word is FCS
			tail_keep = 3'd0;
			tail_fcs = {prev_data[7:0], prev_data[15:8], prev_data[23:16], prev_data[31:24]};
		end else if (end_lane[2]) begin
			tail_keep = 3'd1;
			tail_fcs = {xgmii_rx_data[31:24], prev_data[7:0], prev_data[15:8],
				prev_data[23:16]};
		end else if (end_lane[1]) begin
			tail_keep = 3'd2;
			tail_fcs = {xgmii_rx_data[23:16], xgmii_rx_data[31:24], prev_data[7:0],
				prev_data[15:8]};
		end else begin
			// End in lane 0, three FCS bytes in the current word
			tail_keep = 3'd3;
			tail_fcs = {xgmii_rx_data[15:8], xgmii_rx_data[23:16], xgmii_rx_data[31:24],
				prev_data[7:0]};
		end
	end

	//////////////////////////////
	// Framing FSM

	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			state <= IDLE;
			prev_preamble <= 1'b0;
			rx_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_abort <= 1'b0;
			crc_reset <= 1'b0;
			step <= 1'b0;
		end else begin
			// Check pipeline advances once per accepted word
			step <= xgmii_rx_valid;

			// Single cycle pulses by default
			rx_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_abort <= 1'b0;
			crc_reset <= 1'b0;

			// Stall cycles change nothing
			if (xgmii_rx_valid) begin
				prev_preamble <= (state == PREAMBLE);

				case (state)
					IDLE: begin
						if (xgmii_rx_ctl[3] && (xgmii_rx_data[31:24] == XGMII_CTL_START)) begin
							state <= PREAMBLE;
						end
					end

					PREAMBLE: begin
						crc_reset <= 1'b1;
						// Exactly one preamble word, anything else drops the frame silently
						if ((xgmii_rx_ctl != '0) || (xgmii_rx_data != PREAMBLE_SFD_WORD)) begin
							state <= IDLE;
						end else begin
							state <= BODY;
						end
					end

					BODY: begin
						if (end_lane != '0) begin
							frame_end <= 1'b1;
							rx_valid <= (tail_keep != 3'd0);
							state <= IDLE;
						end else begin
							// Word after the SFD has only the preamble behind it
							rx_valid <= !prev_preamble;
						end
					end

					default: begin
						state <= IDLE;
					end
				endcase

				// In-band error overrides everything else in the frame
				if ((err_lane != '0) && (state != IDLE)) begin
					state <= IDLE;
					frame_abort <= 1'b1;
					frame_end <= 1'b0;
					rx_valid <= 1'b0;
				end
			end
		end
	end

	// Payload path, qualified by rx_valid and frame_end
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			prev_data <= xgmii_rx_data;
			rx_data <= swap_bytes(prev_data);
			rx_keep <= ((state == BODY) && (end_lane != '0)) ? tail_keep : 3'd4;
			fcs_expected <= tail_fcs;
		end
	end

	// CRC sees exactly the bytes that leave on the stream
	assign crc_ce = rx_valid;
	assign crc_len = rx_keep;
	assign crc_din = rx_data;

	//////////////////////////////
	// Checks

	// Start character only ever in lane 3
	a_start_lane3: assert property (@(posedge xgmii_rx_clk) disable iff (reset)
		xgmii_rx_valid |-> (start_low == '0));

	// A word never carries both an end and an error
	a_end_err_excl: assert property (@(posedge xgmii_rx_clk) disable iff (reset)
		xgmii_rx_valid |-> !((end_lane != '0) && (err_lane != '0)));

endmodule

// File: verilog/xgmii_rx_mac.sv
`timescale 1ns/1ns

module xgmii_rx_mac (
	input  logic                       xgmii_rx_clk,
	input  logic                       reset,
	input  logic                       xgmii_rx_valid,
	input  xgmii_rx_pkg::xgmii_ctl_t   xgmii_rx_ctl,
	input  xgmii_rx_pkg::xgmii_data_t  xgmii_rx_data,
	output logic                       rx_valid,
	output xgmii_rx_pkg::xgmii_data_t  rx_data,
	output xgmii_rx_pkg::byte_count_t  rx_keep,
	output logic                       rx_last,
	output logic                       rx_error
);
	import xgmii_rx_pkg::*;

	// Decode to CRC
	logic        crc_reset;
	logic        crc_ce;
	byte_count_t crc_len;
	crc_t        crc_din;

	// Decode to frame check
	crc_t        fcs_expected;
	logic        frame_end;
	logic        frame_abort;
	logic        step;

	crc_t        crc_out;

	//////////////////////////////
	// Decode stage

	xgmii_rx_decode decode_inst (
		.xgmii_rx_clk   (xgmii_rx_clk),
		.reset          (reset),
		.xgmii_rx_valid (xgmii_rx_valid),
		.xgmii_rx_ctl   (xgmii_rx_ctl),
		.xgmii_rx_data  (xgmii_rx_data),
		.rx_valid       (rx_valid),
		.rx_data        (rx_data),
		.rx_keep        (rx_keep),
		.crc_reset      (crc_reset),
		.crc_ce         (crc_ce),
		.crc_len        (crc_len),
		.crc_din        (crc_din),
		.fcs_expected   (fcs_expected),
		.frame_end      (frame_end),
		.frame_abort    (frame_abort),
		.step           (step)
	);

	//////////////////////////////
	// Execute stage

	rx_crc32 crc_inst (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.crc_reset    (crc_reset),
		.crc_ce       (crc_ce),
		.crc_len      (crc_len),
		.crc_din      (crc_din),
		.crc_out      (crc_out)
	);

	//////////////////////////////
	// Result stage

	rx_frame_check check_inst (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.step         (step),
		.fcs_expected (fcs_expected),
		.frame_end    (frame_end),
		.frame_abort  (frame_abort),
		.crc_out      (crc_out),
		.rx_last      (rx_last),
		.rx_error     (rx_error)
	);

endmodule

// File: verilog/xgmii_rx_pkg.sv
package xgmii_rx_pkg;

	//////////////////////////////
	// Bus and datapath widths

	// One XGMII word, lane 3 sits in the top byte and goes first on the wire
	typedef logic [31:0] xgmii_data_t;

	// Per-lane control flags, bit i belongs to lane i
	typedef logic [3:0] xgmii_ctl_t;

	// Single lane character
	typedef logic [7:0] xgmii_char_t;

	// Valid bytes in a word, 0 to 4
	typedef logic [2:0] byte_count_t;

	typedef logic [31:0] crc_t;

	//////////////////////////////
	// XGMII control characters

	localparam xgmii_char_t XGMII_CTL_START = 8'hfb;
	localparam xgmii_char_t XGMII_CTL_END   = 8'hfd;
	localparam xgmii_char_t XGMII_CTL_ERROR = 8'hfe;
	localparam xgmii_char_t XGMII_CTL_IDLE  = 8'h07;

	// Rest of the preamble plus SFD, the word right after the start word
	localparam xgmii_data_t PREAMBLE_SFD_WORD = 32'h555555d5;

	//////////////////////////////
	// Ethernet CRC-32

	// Reflected form of 04C11DB7, shifted out LSB first
	localparam crc_t CRC_POLY = 32'hedb88320;
	localparam crc_t CRC_INIT = 32'hffffffff;

	// Register stages between a CRC input word and its result
	// The frame check delays its expected FCS by the same amount
	localparam int CRC_PIPE_DEPTH = 2;

	//////////////////////////////
	// Receive framing FSM

	typedef enum logic [1:0] {
		IDLE,
		PREAMBLE,
		BODY
	} rx_state_t;

endpackage
